// File: ddr_pkg.sv
// shared widths, timing constants and types for the DDR command controller, imported by every block
package ddr_pkg;

	// memory geometry
	localparam int ROW_W       = 13;
	localparam int COL_W       = 10;
	localparam int BANK_W      = 2;
	localparam int MEM_ADDR_W  = 13;
	localparam int DQ_W        = 16;
	localparam int WORD_W      = 32;
	localparam int USER_ADDR_W = 24;
	// auto-precharge / precharge-all flag on the address pins
	localparam int AP_BIT      = 10;

	typedef logic [15:0]            wait_cnt_t;
	typedef logic [DQ_W-1:0]        dq_t;
	typedef logic [WORD_W-1:0]      word_t;
	typedef logic [ROW_W-1:0]       row_t;
	typedef logic [COL_W-1:0]       col_t;
	typedef logic [BANK_W-1:0]      bank_t;
	typedef logic [MEM_ADDR_W-1:0]  mem_addr_t;
	typedef logic [USER_ADDR_W-1:0] user_addr_t;

	localparam logic [2:0] CAS_LATENCY = 3'd2;
	// mode register code for burst length two
	localparam logic [2:0] BURST_CODE  = 3'd1;

	// waits in ddr_2x_clk cycles, two per memory clock
	localparam wait_cnt_t INIT_WAIT_CYC       = 16'd10000;
	localparam wait_cnt_t DLL_EN_DELAY        = 16'd40000;
	localparam wait_cnt_t LMR_DELAY           = 16'd3;
	localparam wait_cnt_t AUTO_REFRESH_DELAY  = 16'd15;
	localparam wait_cnt_t PRECHARGE_DELAY     = 16'd4;
	localparam wait_cnt_t ACTIVE_TO_RW        = 16'd4;
	localparam wait_cnt_t WRITE_CMD_TO_STROBE = 16'd2;
	localparam wait_cnt_t READ_CAPTURE_DELAY  = wait_cnt_t'(CAS_LATENCY) << 1;
	localparam wait_cnt_t BURST_BEATS         = 16'd2;
	// from read/write command to end of the auto-precharge
	localparam wait_cnt_t WRITE_DONE_WAIT = WRITE_CMD_TO_STROBE + BURST_BEATS + PRECHARGE_DELAY;
	localparam wait_cnt_t READ_DONE_WAIT  = READ_CAPTURE_DELAY + BURST_BEATS + PRECHARGE_DELAY;
	localparam wait_cnt_t REFRESH_INTERVAL = 16'd14000;

	// user address bit 23 picks one of these two banks
	localparam bank_t BANK_HIGH      = 2'd2;
	localparam bank_t BANK_LOW       = 2'd1;
	// mode register select on the bank pins
	localparam bank_t MODE_BANK_BASE = 2'd0;
	localparam bank_t MODE_BANK_EXT  = 2'd1;

	localparam logic       USER_CMD_WRITE = 1'b1;
	localparam logic [2:0] INIT_LAST_STEP = 3'd7;

	typedef enum logic [2:0] {
		CMD_NOP,
		CMD_DESELECT,
		CMD_ACTIVE,
		CMD_READ,
		CMD_WRITE,
		CMD_PRECHARGE,
		CMD_AUTO_REFRESH,
		CMD_LOAD_MODE
	} mem_cmd_e;

	typedef struct packed {
		logic [3:0] rsvd;
		logic       dll_reset;
		logic       op_rsvd;
		logic [2:0] cas_lat;
		logic       burst_type;
		logic [2:0] burst_len;
	} base_mode_t;

	typedef struct packed {
		logic [10:0] rsvd;
		logic        reduced_drive;
		logic        dll_disable;
	} ext_mode_t;

	// one address word, read as base or extended mode by the bank code
	typedef union packed {
		base_mode_t base;
		ext_mode_t  ext;
	} mode_word_u;

	typedef enum logic [2:0] {
		OP_NOP_CKE,
		OP_PRECHARGE_ALL,
		OP_LOAD_EXT,
		OP_LOAD_BASE,
		OP_AUTO_REFRESH
	} init_op_e;

endpackage

// File: ddr_ifs.sv
// bundles between capture, init sequencer, scheduler and data path; instanced in the top level only
interface req_if import ddr_pkg::*; ();
	// held request from the capture stage
	logic  pending;
	logic  write;
	bank_t bank;
	row_t  row;
	col_t  col;
	word_t wdata;
	// take when ACTIVE is chosen, done after the precharge wait
	logic  take;
	logic  done;

	modport producer (output pending, write, bank, row, col, wdata, input take, done);
	modport scheduler (input pending, write, bank, row, col, wdata, output take, done);
endinterface

interface init_if import ddr_pkg::*; ();
	// one strobe per power-up step
	logic       step;
	init_op_e   op;
	bank_t      mode_bank;
	mode_word_u mode;
	// pulses once the step wait has run out
	logic       step_done;

	modport sequencer (output step, op, mode_bank, mode, input step_done);
	modport scheduler (input step, op, mode_bank, mode, output step_done);
endinterface

interface burst_if import ddr_pkg::*; ();
	// strobes in the same cycle as the READ/WRITE choice
	logic  start_write;
	logic  start_read;
	word_t wdata;
	// assembled read word
	word_t rdata;
	logic  rd_valid;

	modport control (output start_write, start_read, wdata, input rdata, rd_valid);
	modport data (input start_write, start_read, wdata, output rdata, rd_valid);
endinterface

// File: user_req_capture.sv
// input side: latches one user request when idle and holds it until the scheduler finishes it
module user_req_capture import ddr_pkg::*; (
	input  logic       ddr_2x_clk,
	input  logic       rst,
	input  logic       user_cmd,
	input  logic       user_cmd_vld,
	input  user_addr_t user_addr,
	input  word_t      user_data_in,
	input  logic       ready,
	output logic       busy,
	req_if.producer    req
);

	logic accept;

	// strobes while busy or during init are dropped, no back-pressure
	assign accept = user_cmd_vld && ready && !busy;

	always_ff @(posedge ddr_2x_clk) begin
		if (rst) begin
			busy        <= 1'b0;
			req.pending <= 1'b0;
		end else if (accept) begin
			busy        <= 1'b1;
			req.pending <= 1'b1;
		end else begin
			// pending clears at ACTIVE, busy only after the precharge wait
			if (req.take) begin
				req.pending <= 1'b0;
			end
			if (req.done) begin
				busy <= 1'b0;
			end
		end
	end

	// request payload, split into bank code, row and column
	always_ff @(posedge ddr_2x_clk) begin
		if (accept) begin
			req.write <= (user_cmd == USER_CMD_WRITE);
			req.wdata <= user_data_in;
			req.bank  <= user_addr[USER_ADDR_W-1] ? BANK_HIGH : BANK_LOW;
			req.row   <= user_addr[COL_W +: ROW_W];
			req.col   <= user_addr[COL_W-1:0];
		end
	end

endmodule

// File: init_sequencer.sv
// power-up list for the DDR part: hands one step at a time to the scheduler, then raises ready
module init_sequencer import ddr_pkg::*; (
	input  logic       ddr_2x_clk,
	input  logic       rst,
	output logic       ready,
	init_if.sequencer  init
);

	logic [2:0] step_idx;
	logic       waiting;
	mode_word_u mode_word;

	always_ff @(posedge ddr_2x_clk) begin
		if (rst) begin
			step_idx  <= '0;
			waiting   <= 1'b0;
			ready     <= 1'b0;
			init.step <= 1'b0;
		end else begin
			init.step <= 1'b0;
			if (!ready && !waiting) begin
				// issue the current step, then hold for its wait
				init.step <= 1'b1;
				waiting   <= 1'b1;
			end else if (waiting && init.step_done) begin
				waiting <= 1'b0;
				if (step_idx == INIT_LAST_STEP) begin
					ready <= 1'b1;
				end else begin
					step_idx <= step_idx + 3'd1;
				end
			end
		end
	end

	// step table, mode words are built through the union
	always_comb begin
		mode_word      = '0;
		init.mode_bank = MODE_BANK_BASE;
		init.op        = OP_AUTO_REFRESH;
		case (step_idx)
			3'd0: begin
				init.op = OP_NOP_CKE;
			end
			3'd1, 3'd4: begin
				init.op = OP_PRECHARGE_ALL;
			end
			3'd2: begin
				// DLL on, full drive strength
				init.op                   = OP_LOAD_EXT;
				init.mode_bank            = MODE_BANK_EXT;
				mode_word.ext.dll_disable   = 1'b0;
				mode_word.ext.reduced_drive = 1'b0;
			end
			3'd3, 3'd7: begin
				// burst of two, sequential, DLL reset only on the first load
				init.op                   = OP_LOAD_BASE;
				mode_word.base.burst_len  = BURST_CODE;
				mode_word.base.burst_type = 1'b0;
				mode_word.base.cas_lat    = CAS_LATENCY;
				mode_word.base.dll_reset  = (step_idx == 3'd3);
			end
			default: begin
				// steps 5 and 6, two auto refreshes
				init.op = OP_AUTO_REFRESH;
			end
		endcase
		init.mode = mode_word;
	end

endmodule

// File: cmd_scheduler.sv
// main command FSM: runs init steps, then arbitrates refresh against single user accesses
module cmd_scheduler import ddr_pkg::*; (
	input  logic       ddr_2x_clk,
	input  logic       rst,
	input  logic       ready,
	req_if.scheduler   req,
	init_if.scheduler  init,
	burst_if.control   burst,
	output mem_cmd_e   cmd,
	output bank_t      ba,
	output mem_addr_t  addr,
	output logic       cke_on,
	output logic       ack
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_INIT_WAIT,
		S_REF_WAIT,
		S_ACT_WAIT,
		S_XFER_WAIT
	} sched_state_e;

	sched_state_e state;
	sched_state_e next_state;
	wait_cnt_t    wait_cnt;
	wait_cnt_t    load_val;
	logic         load;
	wait_cnt_t    ref_timer;
	logic         refresh_due;
	logic         cke_en;

	assign refresh_due = (ref_timer == REFRESH_INTERVAL);
	assign cke_on      = cke_en;
	// write word was already latched at capture
	assign burst.wdata = req.wdata;

	// command choice, goes out on the pins one cycle later
	always_comb begin
		// idle cycles: deselect while CKE is low, NOP after
		cmd               = cke_en ? CMD_NOP : CMD_DESELECT;
		ba                = '0;
		addr              = '0;
		load              = 1'b0;
		load_val          = '0;
		next_state        = state;
		req.take          = 1'b0;
		req.done          = 1'b0;
		init.step_done    = 1'b0;
		burst.start_write = 1'b0;
		burst.start_read  = 1'b0;
		case (state)
			S_IDLE: begin
				if (!ready) begin
					if (init.step) begin
						load       = 1'b1;
						next_state = S_INIT_WAIT;
						case (init.op)
							OP_NOP_CKE: begin
								// CKE stays low for the whole wait
								load_val = INIT_WAIT_CYC;
							end
							OP_PRECHARGE_ALL: begin
								cmd          = CMD_PRECHARGE;
								addr[AP_BIT] = 1'b1;
								load_val     = PRECHARGE_DELAY;
							end
							OP_AUTO_REFRESH: begin
								cmd      = CMD_AUTO_REFRESH;
								load_val = AUTO_REFRESH_DELAY;
							end
							default: begin
								// base or extended mode load
								cmd  = CMD_LOAD_MODE;
								ba   = init.mode_bank;
								addr = init.mode;
								if (init.op == OP_LOAD_EXT && !init.mode.ext.dll_disable) begin
									load_val = DLL_EN_DELAY;
								end else begin
									load_val = LMR_DELAY;
								end
							end
						endcase
					end
				end else if (refresh_due) begin
					// refresh wins over a waiting request
					cmd        = CMD_AUTO_REFRESH;
					load       = 1'b1;
					load_val   = AUTO_REFRESH_DELAY;
					next_state = S_REF_WAIT;
				end else if (req.pending) begin
					cmd        = CMD_ACTIVE;
					ba         = req.bank;
					addr       = req.row;
					req.take   = 1'b1;
					load       = 1'b1;
					load_val   = ACTIVE_TO_RW;
					next_state = S_ACT_WAIT;
				end
			end
			S_INIT_WAIT: begin
				if (wait_cnt == '0) begin
					init.step_done = 1'b1;
					next_state     = S_IDLE;
				end
			end
			S_REF_WAIT: begin
				if (wait_cnt == '0) begin
					next_state = S_IDLE;
				end
			end
			S_ACT_WAIT: begin
				// tRCD met, column command with auto-precharge
				if (wait_cnt == '0) begin
					ba           = req.bank;
					addr         = {{(MEM_ADDR_W-COL_W){1'b0}}, req.col};
					addr[AP_BIT] = 1'b1;
					load         = 1'b1;
					next_state   = S_XFER_WAIT;
					if (req.write) begin
						cmd               = CMD_WRITE;
						burst.start_write = 1'b1;
						load_val          = WRITE_DONE_WAIT;
					end else begin
						cmd              = CMD_READ;
						burst.start_read = 1'b1;
						load_val         = READ_DONE_WAIT;
					end
				end
			end
			S_XFER_WAIT: begin
				// burst and precharge both over
				if (wait_cnt == '0) begin
					req.done   = 1'b1;
					next_state = S_IDLE;
				end
			end
			default: begin
				next_state = S_IDLE;
			end
		endcase
	end

	always_ff @(posedge ddr_2x_clk) begin
		if (rst) begin
			state     <= S_IDLE;
			wait_cnt  <= '0;
			ref_timer <= '0;
			cke_en    <= 1'b0;
			ack       <= 1'b0;
		end else begin
			state <= next_state;
			// lines up with ACTIVE on the pins
			ack   <= req.take;
			if (load) begin
				wait_cnt <= load_val;
			end else if (wait_cnt != '0) begin
				wait_cnt <= wait_cnt - 16'd1;
			end
			if (init.step_done && init.op == OP_NOP_CKE) begin
				cke_en <= 1'b1;
			end
			// timer runs only once ready, restarts when the refresh goes out
			if (!ready || (state == S_IDLE && refresh_due)) begin
				ref_timer <= '0;
			end else if (!refresh_due) begin
				ref_timer <= ref_timer + 16'd1;
			end
		end
	end

endmodule

// File: phy_cmd_out.sv
// output side: registers the chosen command onto the memory control, bank and address pins
module phy_cmd_out import ddr_pkg::*; (
	input  logic      ddr_2x_clk,
	input  logic      rst,
	input  mem_cmd_e  cmd,
	input  bank_t     ba,
	input  mem_addr_t addr,
	input  logic      cke_on,
	output logic      mem_cke,
	output logic      mem_cs,
	output logic      mem_ras,
	output logic      mem_cas,
	output logic      mem_we,
	output bank_t     mem_ba,
	output mem_addr_t mem_addr
);

	// cs, ras, cas, we
	logic [3:0] ctl;

	always_comb begin
		case (cmd)
			CMD_NOP:          ctl = 4'b0111;
			CMD_ACTIVE:       ctl = 4'b0011;
			CMD_READ:         ctl = 4'b0101;
			CMD_WRITE:        ctl = 4'b0100;
			CMD_PRECHARGE:    ctl = 4'b0010;
			CMD_AUTO_REFRESH: ctl = 4'b0001;
			CMD_LOAD_MODE:    ctl = 4'b0000;
			default:          ctl = 4'b1111;
		endcase
	end

	always_ff @(posedge ddr_2x_clk) begin
		if (rst) begin
			// deselect with CKE low out of reset
			{mem_cs, mem_ras, mem_cas, mem_we} <= 4'b1111;
			mem_cke                            <= 1'b0;
		end else begin
			{mem_cs, mem_ras, mem_cas, mem_we} <= ctl;
			mem_cke                            <= cke_on;
		end
	end

	always_ff @(posedge ddr_2x_clk) begin
		mem_ba   <= ba;
		mem_addr <= addr;
	end

endmodule

// File: burst_data_path.sv
// output side data path: drives the two write beats with DQS and joins the two read beats into a word
module burst_data_path import ddr_pkg::*; (
	input  logic        ddr_2x_clk,
	input  logic        rst,
	input  dq_t         dq_in,
	burst_if.data       burst,
	output logic [1:0]  mem_dqs,
	output dq_t         dq_out,
	output logic        dq_oe
);

	typedef enum logic [2:0] {
		P_IDLE,
		P_WR_WAIT,
		P_WR_LO,
		P_RD_WAIT,
		P_RD_LO
	} phase_e;

	phase_e    phase;
	wait_cnt_t cnt;
	word_t     wr_word;
	dq_t       rd_hi;

	always_ff @(posedge ddr_2x_clk) begin
		if (rst) begin
			phase          <= P_IDLE;
			cnt            <= '0;
			dq_oe          <= 1'b0;
			mem_dqs        <= '0;
			burst.rd_valid <= 1'b0;
		end else begin
			burst.rd_valid <= 1'b0;
			case (phase)
				P_IDLE: begin
					dq_oe <= 1'b0;
					if (burst.start_write) begin
						cnt   <= WRITE_CMD_TO_STROBE;
						phase <= P_WR_WAIT;
					end else if (burst.start_read) begin
						cnt   <= READ_CAPTURE_DELAY;
						phase <= P_RD_WAIT;
					end
				end
				P_WR_WAIT: begin
					if (cnt == '0) begin
						// top half goes out first
						dq_oe   <= 1'b1;
						mem_dqs <= ~mem_dqs;
						phase   <= P_WR_LO;
					end else begin
						cnt <= cnt - 16'd1;
					end
				end
				P_WR_LO: begin
					mem_dqs <= ~mem_dqs;
					phase   <= P_IDLE;
				end
				P_RD_WAIT: begin
					if (cnt == '0) begin
						phase <= P_RD_LO;
					end else begin
						cnt <= cnt - 16'd1;
					end
				end
				P_RD_LO: begin
					burst.rd_valid <= 1'b1;
					phase          <= P_IDLE;
				end
				default: begin
					phase <= P_IDLE;
				end
			endcase
		end
	end

	// beat data, the write word is held from the start strobe
	always_ff @(posedge ddr_2x_clk) begin
		if (phase == P_IDLE && burst.start_write) begin
			wr_word <= burst.wdata;
		end
		if (phase == P_WR_WAIT && cnt == '0) begin
			dq_out <= wr_word[WORD_W-1:DQ_W];
		end
		if (phase == P_WR_LO) begin
			dq_out <= wr_word[DQ_W-1:0];
		end
		if (phase == P_RD_WAIT && cnt == '0) begin
			rd_hi <= dq_in;
		end
		if (phase == P_RD_LO) begin
			burst.rdata <= {rd_hi, dq_in};
		end
	end

endmodule

// File: ddr_ctrl_top.sv
// top level of the DDR command controller: user ports and memory pins, blocks wired by interfaces
module ddr_ctrl_top import ddr_pkg::*; (
	input  logic       ddr_2x_clk,
	input  logic       rst,
	input  logic       user_cmd,
	input  logic       user_cmd_vld,
	input  user_addr_t user_addr,
	input  word_t      user_data_in,
	input  dq_t        dq_in,
	output word_t      user_data_out,
	output logic       user_data_vld,
	output logic       ddr_busy,
	output logic       ddr_ack,
	output logic       ddr_ready,
	output logic       mem_cke,
	output logic       mem_cs,
	output logic       mem_ras,
	output logic       mem_cas,
	output logic       mem_we,
	output bank_t      mem_ba,
	output mem_addr_t  mem_addr,
	output logic [1:0] mem_dqs,
	output dq_t        dq_out,
	output logic       dq_oe
);

	// scheduler to pin register
	mem_cmd_e  sched_cmd;
	bank_t     sched_ba;
	mem_addr_t sched_addr;
	logic      sched_cke;

	req_if   req_bus ();
	init_if  init_bus ();
	burst_if burst_bus ();

	user_req_capture capture (
		.ddr_2x_clk   (ddr_2x_clk),
		.rst          (rst),
		.user_cmd     (user_cmd),
		.user_cmd_vld (user_cmd_vld),
		.user_addr    (user_addr),
		.user_data_in (user_data_in),
		.ready        (ddr_ready),
		.busy         (ddr_busy),
		.req          (req_bus.producer)
	);

	init_sequencer init_seq (
		.ddr_2x_clk (ddr_2x_clk),
		.rst        (rst),
		.ready      (ddr_ready),
		.init       (init_bus.sequencer)
	);

	cmd_scheduler sched (
		.ddr_2x_clk (ddr_2x_clk),
		.rst        (rst),
		.ready      (ddr_ready),
		.req        (req_bus.scheduler),
		.init       (init_bus.scheduler),
		.burst      (burst_bus.control),
		.cmd        (sched_cmd),
		.ba         (sched_ba),
		.addr       (sched_addr),
		.cke_on     (sched_cke),
		.ack        (ddr_ack)
	);

	phy_cmd_out phy_out (
		.ddr_2x_clk (ddr_2x_clk),
		.rst        (rst),
		.cmd        (sched_cmd),
		.ba         (sched_ba),
		.addr       (sched_addr),
		.cke_on     (sched_cke),
		.mem_cke    (mem_cke),
		.mem_cs     (mem_cs),
		.mem_ras    (mem_ras),
		.mem_cas    (mem_cas),
		.mem_we     (mem_we),
		.mem_ba     (mem_ba),
		.mem_addr   (mem_addr)
	);

	burst_data_path data_path (
		.ddr_2x_clk (ddr_2x_clk),
		.rst        (rst),
		.dq_in      (dq_in),
		.burst      (burst_bus.data),
		.mem_dqs    (mem_dqs),
		.dq_out     (dq_out),
		.dq_oe      (dq_oe)
	);

	// read word straight from the data path
	assign user_data_out = burst_bus.rdata;
	assign user_data_vld = burst_bus.rd_valid;

endmodule

// File: tb_ddr_ctrl.sv
// self-checking testbench for the DDR command controller, run with ddr_stimulus.txt in the project root
module tb_ddr_ctrl import ddr_pkg::*; ();

	logic       ddr_2x_clk;
	logic       rst;
	logic       user_cmd;
	logic       user_cmd_vld;
	user_addr_t user_addr;
	word_t      user_data_in;
	dq_t        dq_in;
	word_t      user_data_out;
	logic       user_data_vld;
	logic       ddr_busy;
	logic       ddr_ack;
	logic       ddr_ready;
	logic       mem_cke;
	logic       mem_cs;
	logic       mem_ras;
	logic       mem_cas;
	logic       mem_we;
	bank_t      mem_ba;
	mem_addr_t  mem_addr;
	logic [1:0] mem_dqs;
	dq_t        dq_out;
	logic       dq_oe;

	// run bookkeeping
	int     cycles = 0;
	int     cycle_limit = 1000000;
	int     error_count = 0;
	int     check_count = 0;
	int     tests_run = 0;
	int     tests_failed = 0;
	int     test_err_start = 0;
	int     ready_cycle = -1;
	int     cke_nop_cycle = -1;
	int     ref_cycle = -1;
	integer seed = 90;

	// stimulus lines from the file
	logic [7:0] stim_op [$];
	user_addr_t stim_addr [$];
	word_t      stim_wdata [$];
	word_t      stim_exp [$];

	// every command seen on the pins, NOP and deselect left out
	mem_cmd_e  log_cmd [$];
	bank_t     log_ba [$];
	mem_addr_t log_addr [$];
	int        log_cyc [$];

	// memory model state, key is bank, row, column and beat
	dq_t       mem_store [bit [25:0]];
	mem_addr_t open_row [4];
	mem_cmd_e  pin_cmd;
	bit [25:0] wr_key;
	bit [25:0] rd_key;
	int        wr_at = -1;
	int        rd_at = -1;

	ddr_ctrl_top dut0 (
		.ddr_2x_clk    (ddr_2x_clk),
		.rst           (rst),
		.user_cmd      (user_cmd),
		.user_cmd_vld  (user_cmd_vld),
		.user_addr     (user_addr),
		.user_data_in  (user_data_in),
		.dq_in         (dq_in),
		.user_data_out (user_data_out),
		.user_data_vld (user_data_vld),
		.ddr_busy      (ddr_busy),
		.ddr_ack       (ddr_ack),
		.ddr_ready     (ddr_ready),
		.mem_cke       (mem_cke),
		.mem_cs        (mem_cs),
		.mem_ras       (mem_ras),
		.mem_cas       (mem_cas),
		.mem_we        (mem_we),
		.mem_ba        (mem_ba),
		.mem_addr      (mem_addr),
		.mem_dqs       (mem_dqs),
		.dq_out        (dq_out),
		.dq_oe         (dq_oe)
	);

	initial begin
		ddr_2x_clk = 1'b0;
		forever #4 ddr_2x_clk = ~ddr_2x_clk;
	end

	// cycle count and run limit
	always @(posedge ddr_2x_clk) begin
		cycles = cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: run still going after %0d cycles", cycle_limit);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// JEDEC truth table on cs, ras, cas, we
	function automatic mem_cmd_e pins_to_cmd(input logic cs, input logic ras, input logic cas,
			input logic we);
		case ({cs, ras, cas, we})
			4'b0111: return CMD_NOP;
			4'b0011: return CMD_ACTIVE;
			4'b0101: return CMD_READ;
			4'b0100: return CMD_WRITE;
			4'b0010: return CMD_PRECHARGE;
			4'b0001: return CMD_AUTO_REFRESH;
			4'b0000: return CMD_LOAD_MODE;
			default: return CMD_DESELECT;
		endcase
	endfunction

	// unwritten locations read back as zero
	function automatic dq_t read_beat(input bit [25:0] key);
		if (mem_store.exists(key)) begin
			return mem_store[key];
		end
		return '0;
	endfunction

	// pin monitor and memory model, just after each rising edge
	always @(posedge ddr_2x_clk) begin
		#1;
		if (!rst) begin
			pin_cmd = pins_to_cmd(mem_cs, mem_ras, mem_cas, mem_we);
			if (pin_cmd == CMD_NOP && mem_cke && cke_nop_cycle < 0) begin
				cke_nop_cycle = cycles;
			end
			if (pin_cmd != CMD_NOP && pin_cmd != CMD_DESELECT) begin
				log_cmd.push_back(pin_cmd);
				log_ba.push_back(mem_ba);
				log_addr.push_back(mem_addr);
				log_cyc.push_back(cycles);
			end
			if (pin_cmd == CMD_AUTO_REFRESH && ddr_ready && ref_cycle < 0) begin
				ref_cycle = cycles;
			end
			if (pin_cmd == CMD_ACTIVE) begin
				open_row[mem_ba] = mem_addr;
			end
			if (pin_cmd == CMD_WRITE) begin
				wr_at  = cycles;
				wr_key = {mem_ba, open_row[mem_ba], mem_addr[COL_W-1:0], 1'b0};
			end
			if (pin_cmd == CMD_READ) begin
				rd_at  = cycles;
				rd_key = {mem_ba, open_row[mem_ba], mem_addr[COL_W-1:0], 1'b0};
			end
			// write beats land at fixed offsets from WRITE
			if (wr_at >= 0 && dq_oe && cycles == wr_at + WRITE_CMD_TO_STROBE + 1) begin
				mem_store[wr_key] = dq_out;
			end else if (wr_at >= 0 && dq_oe && cycles == wr_at + WRITE_CMD_TO_STROBE + 2) begin
				mem_store[wr_key | 26'd1] = dq_out;
			end
			// read beats, junk on the bus at any other time
			if (rd_at >= 0 && cycles == rd_at + READ_CAPTURE_DELAY) begin
				dq_in = read_beat(rd_key);
			end else if (rd_at >= 0 && cycles == rd_at + READ_CAPTURE_DELAY + 1) begin
				dq_in = read_beat(rd_key | 26'd1);
			end else begin
				dq_in = $random(seed);
			end
		end
	end

	task automatic report_problem(input string msg);
		$display("%s", msg);
		error_count++;
	endtask

	task automatic check_cmd(input string name, input mem_cmd_e got, input mem_cmd_e exp);
		check_count++;
		if (got !== exp) begin
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		check_count++;
		if (got !== exp) begin
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_mode(input string name, input mode_word_u got, input mode_word_u exp);
		check_count++;
		if (got !== exp) begin
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_addr(input string name, input mem_addr_t got, input mem_addr_t exp);
		check_count++;
		if (got !== exp) begin
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_bank(input string name, input bank_t got, input bank_t exp);
		check_count++;
		if (got !== exp) begin
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		check_count++;
		if (got !== exp) begin
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_dqs(input string name, input logic [1:0] got, input logic [1:0] exp);
		check_count++;
		if (got !== exp) begin
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
			error_count++;
		end
	endtask

	// one line per finished test
	task automatic finish_test(input string name);
		tests_run++;
		if (error_count == test_err_start) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, error_count - test_err_start);
		end
		test_err_start = error_count;
	endtask

	// lines starting with # are skipped, others are op, address, data, expected
	task automatic load_stimulus();
		int         fd;
		int         c;
		int         n;
		user_addr_t a;
		word_t      w;
		word_t      e;
		fd = $fopen("ddr_stimulus.txt", "r");
		if (fd == 0) begin
			report_problem("could not open ddr_stimulus.txt");
		end else begin
			c = $fgetc(fd);
			while (c != -1) begin
				if (c == "#") begin
					while (c != "\n" && c != -1) begin
						c = $fgetc(fd);
					end
				end else if (c == "W" || c == "R") begin
					n = $fscanf(fd, "%h %h %h", a, w, e);
					if (n == 3) begin
						stim_op.push_back(c[7:0]);
						stim_addr.push_back(a);
						stim_wdata.push_back(w);
						stim_exp.push_back(e);
					end else begin
						report_problem("stimulus line with missing fields");
					end
				end
				if (c != -1) begin
					c = $fgetc(fd);
				end
			end
			$fclose(fd);
		end
		if (stim_op.size() == 0) begin
			report_problem("no stimulus lines were read");
		end
	endtask

	// one user access, checked on the pins and at the user side
	task automatic run_access(input logic [7:0] op, input user_addr_t addr, input word_t wdata,
			input word_t exp);
		bank_t      exp_bank;
		mem_addr_t  exp_col;
		logic [1:0] dqs_prev;
		dq_t        beat_hi;
		dq_t        beat_lo;
		exp_bank         = addr[USER_ADDR_W-1] ? BANK_HIGH : BANK_LOW;
		exp_col          = mem_addr_t'(addr[COL_W-1:0]);
		exp_col[AP_BIT]  = 1'b1;
		do @(negedge ddr_2x_clk); while (!(ddr_ready && !ddr_busy));
		@(posedge ddr_2x_clk);
		#1;
		user_cmd     = (op == "W");
		user_cmd_vld = 1'b1;
		user_addr    = addr;
		user_data_in = wdata;
		@(posedge ddr_2x_clk);
		#1;
		user_cmd_vld = 1'b0;
		check_bit("ddr_busy after strobe", ddr_busy, 1'b1);
		// ACTIVE lines up with ack
		do @(negedge ddr_2x_clk); while (!ddr_ack);
		check_cmd("pin command at ack", pins_to_cmd(mem_cs, mem_ras, mem_cas, mem_we), CMD_ACTIVE);
		check_bank("mem_ba at ACTIVE", mem_ba, exp_bank);
		check_addr("mem_addr row", mem_addr, mem_addr_t'(addr[COL_W +: ROW_W]));
		@(negedge ddr_2x_clk);
		check_bit("ddr_ack second cycle", ddr_ack, 1'b0);
		repeat (ACTIVE_TO_RW) @(negedge ddr_2x_clk);
		check_bank("mem_ba at column command", mem_ba, exp_bank);
		check_addr("mem_addr column", mem_addr, exp_col);
		if (op == "W") begin
			check_cmd("column command", pins_to_cmd(mem_cs, mem_ras, mem_cas, mem_we), CMD_WRITE);
			repeat (WRITE_CMD_TO_STROBE) @(negedge ddr_2x_clk);
			dqs_prev = mem_dqs;
			@(negedge ddr_2x_clk);
			check_bit("dq_oe first beat", dq_oe, 1'b1);
			check_dqs("mem_dqs first beat", mem_dqs, ~dqs_prev);
			beat_hi  = dq_out;
			dqs_prev = mem_dqs;
			@(negedge ddr_2x_clk);
			check_bit("dq_oe second beat", dq_oe, 1'b1);
			check_dqs("mem_dqs second beat", mem_dqs, ~dqs_prev);
			beat_lo = dq_out;
			// top half goes first
			check_word("dq_out beats", {beat_hi, beat_lo}, wdata);
		end else begin
			check_cmd("column command", pins_to_cmd(mem_cs, mem_ras, mem_cas, mem_we), CMD_READ);
			do @(negedge ddr_2x_clk); while (!user_data_vld);
			check_word("user_data_out", user_data_out, exp);
			check_bit("ddr_busy at read data", ddr_busy, 1'b1);
			@(negedge ddr_2x_clk);
			check_bit("user_data_vld second cycle", user_data_vld, 1'b0);
		end
		while (ddr_busy) begin
			@(negedge ddr_2x_clk);
		end
	endtask

	initial begin
		int i;
		int last_read;
		rst          = 1'b1;
		user_cmd     = 1'b0;
		user_cmd_vld = 1'b0;
		user_addr    = '0;
		user_data_in = '0;
		dq_in        = '0;
		last_read    = -1;
		load_stimulus();
		// power-up waits, one refresh period, then room for each access
		cycle_limit = int'(INIT_WAIT_CYC) + int'(DLL_EN_DELAY) + int'(REFRESH_INTERVAL) + 200
			+ 64 * stim_op.size();

		// reset values, sampled while reset is still held
		repeat (3) @(posedge ddr_2x_clk);
		@(negedge ddr_2x_clk);
		check_bit("ddr_ready", ddr_ready, 1'b0);
		check_bit("ddr_busy", ddr_busy, 1'b0);
		check_bit("ddr_ack", ddr_ack, 1'b0);
		check_bit("user_data_vld", user_data_vld, 1'b0);
		check_bit("dq_oe", dq_oe, 1'b0);
		check_bit("mem_cke", mem_cke, 1'b0);
		check_bit("mem_cs", mem_cs, 1'b1);
		@(posedge ddr_2x_clk);
		#1;
		rst = 1'b0;
		finish_test("reset");

		// power-up list as seen on the pins
		while (!ddr_ready) begin
			@(negedge ddr_2x_clk);
		end
		ready_cycle = cycles;
		if (log_cmd.size() != 7) begin
			report_problem($sformatf("init issued %0d commands instead of 7", log_cmd.size()));
		end else begin
			if (cke_nop_cycle < 0 || cke_nop_cycle > log_cyc[0]) begin
				report_problem("no NOP with CKE high before the first precharge");
			end
			check_cmd("init command 0", log_cmd[0], CMD_PRECHARGE);
			check_bit("precharge all flag", log_addr[0][AP_BIT], 1'b1);
			check_cmd("init command 1", log_cmd[1], CMD_LOAD_MODE);
			check_bank("extended mode bank", log_ba[1], 2'd1);
			check_mode("extended mode word", mode_word_u'(log_addr[1]), mode_word_u'(13'h000));
			check_cmd("init command 2", log_cmd[2], CMD_LOAD_MODE);
			check_bank("base mode bank", log_ba[2], 2'd0);
			check_mode("base mode word", mode_word_u'(log_addr[2]), mode_word_u'(13'h121));
			check_cmd("init command 3", log_cmd[3], CMD_PRECHARGE);
			check_bit("precharge all flag", log_addr[3][AP_BIT], 1'b1);
			check_cmd("init command 4", log_cmd[4], CMD_AUTO_REFRESH);
			check_cmd("init command 5", log_cmd[5], CMD_AUTO_REFRESH);
			check_cmd("init command 6", log_cmd[6], CMD_LOAD_MODE);
			check_bank("final mode bank", log_ba[6], 2'd0);
			check_mode("final mode word", mode_word_u'(log_addr[6]), mode_word_u'(13'h021));
		end
		finish_test("init");

		for (i = 0; i < stim_op.size(); i++) begin
			run_access(stim_op[i], stim_addr[i], stim_wdata[i], stim_exp[i]);
			if (stim_op[i] == "R") begin
				last_read = i;
			end
			finish_test($sformatf("access %0d %c 0x%h", i, stim_op[i], stim_addr[i]));
		end

		// first refresh after ready, then a read must still be right
		while (ref_cycle < 0) begin
			@(negedge ddr_2x_clk);
		end
		if (ref_cycle - ready_cycle < int'(REFRESH_INTERVAL)) begin
			report_problem($sformatf("refresh came %0d cycles after ready, too early",
				ref_cycle - ready_cycle));
		end
		if (ref_cycle - ready_cycle >= 2 * int'(REFRESH_INTERVAL)) begin
			report_problem($sformatf("refresh came %0d cycles after ready, too late",
				ref_cycle - ready_cycle));
		end
		if (last_read < 0) begin
			report_problem("no read line to repeat after the refresh");
		end else begin
			run_access(stim_op[last_read], stim_addr[last_read], stim_wdata[last_read],
				stim_exp[last_read]);
		end
		finish_test("refresh");

		$display("summary: %0d tests, %0d failed, %0d checks, %0d errors", tests_run, tests_failed,
			check_count, error_count);
		if (error_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: ddr_stimulus.txt
# op (W write, R read), user address hex 24 bit, write data hex, expected read data hex
# address bit 23 picks the bank, bits 22 to 10 the row, bits 9 to 0 the column
W 800400 cafef00d 00000000
W 000000 12345678 00000000
W 7ffffe a5a55a5a 00000000
W 81234c 0badbeef 00000000
R 800400 00000000 cafef00d
R 000000 00000000 12345678
W 800400 deadbeef 00000000
R 81234c 00000000 0badbeef
R 7ffffe 00000000 a5a55a5a
R 800400 00000000 deadbeef

// File: build.f
ddr_pkg.sv
ddr_ifs.sv
user_req_capture.sv
init_sequencer.sv
cmd_scheduler.sv
phy_cmd_out.sv
burst_data_path.sv
ddr_ctrl_top.sv
tb_ddr_ctrl.sv

// File: Bender.yml
package:
  name: ddr_ctrl

sources:
  - ddr_pkg.sv
  - ddr_ifs.sv
  - user_req_capture.sv
  - init_sequencer.sv
  - cmd_scheduler.sv
  - phy_cmd_out.sv
  - burst_data_path.sv
  - ddr_ctrl_top.sv
  - target: test
    files:
      - tb_ddr_ctrl.sv
